// ==== compile.f ====
hw/inoc_pkg.sv
hw/record_fifo.sv
hw/group_table.sv
hw/req_arbiter.sv
hw/flit_broadcast.sv
hw/loop_sequencer.sv
hw/inoc_ctrl_top.sv
dv/inoc_tb.sv

// ==== dv/inoc_tb.sv ====
// ================================================
// testbench of the NoC DMA control unit: buffer and
// node models, expected flit queues per node, checks
// ================================================
`timescale 1ns/100ps

module inoc_tb;

    localparam int MAX_WAIT = 20000;

    logic                  clk, rst_n, fsm_start, fsm_auto_restart_en, fsm_restart;
    inoc_pkg::word_addr_t  fsm_base_addr, ibuffer_word_addr;
    inoc_pkg::word_num_t   ibuffer_word_num;
    logic                  ibuffer_rd_start, return_valid, return_ready;
    logic                  return_last, return_done;
    inoc_pkg::flit_t       return_data, send_flit;
    inoc_pkg::node_mask_t  send_valid, send_ready, recv_valid, recv_ready, nodes_status;
    inoc_pkg::node_flits_t recv_flit;
    logic                  small_loop_end_int, finish_intr;

    inoc_pkg::flit_t      mem [2**17];
    inoc_pkg::flit_t      exp_q [inoc_pkg::NUM_NODES][$];
    inoc_pkg::node_mask_t rec_mask [32];
    inoc_pkg::flit_t      rec_flit [32];
    int                   pending, fin_cnt, errors;

    inoc_ctrl_top i_dut (
        .clk(clk), .rst_n(rst_n), .fsm_start(fsm_start), .fsm_base_addr(fsm_base_addr),
        .fsm_auto_restart_en(fsm_auto_restart_en), .fsm_restart(fsm_restart),
        .ibuffer_rd_start(ibuffer_rd_start), .ibuffer_word_addr(ibuffer_word_addr),
        .ibuffer_word_num(ibuffer_word_num), .return_valid(return_valid),
        .return_ready(return_ready), .return_data(return_data), .return_last(return_last),
        .return_done(return_done), .send_valid(send_valid), .send_flit(send_flit),
        .send_ready(send_ready), .recv_valid(recv_valid), .recv_flit(recv_flit),
        .recv_ready(recv_ready), .nodes_status(nodes_status),
        .small_loop_end_int(small_loop_end_int), .finish_intr(finish_intr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s expected %0h actual %0h", name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic abort_run(string msg);
        $display("ERROR: %s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // ================================================
    // stimulus and expected values
    // ================================================
    // disjoint non-zero groups, the last record carries the loop opcode
    function automatic void build_loop(int first, int n, inoc_pkg::opcode_t op);
        int base, sel;
        inoc_pkg::flit_t gw;
        for (int r = 0; r < n; r++) rec_mask[first + r] = '0;
        base = $urandom % inoc_pkg::NUM_NODES;
        for (int k = 0; k < inoc_pkg::NUM_NODES; k++) begin
            sel = (k < n) ? k : $urandom % (n + 1);
            if (sel < n) rec_mask[first + sel][(base + k) % inoc_pkg::NUM_NODES] = 1'b1;
        end
        for (int r = 0; r < n; r++) begin
            rec_flit[first + r] = $urandom;
            gw = $urandom;
            gw[27:16] = rec_mask[first + r];
            gw[6:0] = (r == n - 1) ? op : inoc_pkg::op_group;
            mem[2 * (first + r)] = rec_flit[first + r];
            mem[2 * (first + r) + 1] = gw;
        end
    endfunction

    task automatic queue_config(int first, int n);
        for (int r = first; r < first + n; r++) begin
            for (int i = 0; i < inoc_pkg::NUM_NODES; i++) begin
                if (rec_mask[r][i]) begin
                    exp_q[i].push_back(rec_flit[r]);
                    pending++;
                end
            end
        end
    endtask

    task automatic queue_block(inoc_pkg::node_mask_t dest, int len, inoc_pkg::word_addr_t addr);
        for (int k = 0; k < len; k++) begin
            for (int i = 0; i < inoc_pkg::NUM_NODES; i++) begin
                if (dest[i]) begin
                    exp_q[i].push_back(mem[inoc_pkg::word_addr_t'(addr + k)]);
                    pending++;
                end
            end
        end
    endtask

    task automatic wait_delivered(string what);
        int cnt;
        cnt = 0;
        while (pending != 0) begin
            @(negedge clk);
            cnt++;
            if (cnt > MAX_WAIT) abort_run($sformatf("%s not delivered in time", what));
        end
        @(posedge clk);
    endtask

    task automatic wait_finish(int count);
        int cnt;
        cnt = 0;
        while (fin_cnt < count) begin
            @(negedge clk);
            cnt++;
            if (cnt > MAX_WAIT) abort_run("finish interrupt did not arrive in time");
        end
        check("finish_count", count, fin_cnt);
        @(posedge clk);
    endtask

    task automatic start_unit(inoc_pkg::word_addr_t base);
        fsm_start     <= 1'b1;
        fsm_base_addr <= base;
        @(negedge clk);
        check("start_rd", 1, ibuffer_rd_start);
        check("start_addr", base, ibuffer_word_addr);
        check("start_num", 8, ibuffer_word_num);
        @(posedge clk);
        fsm_start <= 1'b0;
    endtask

    task automatic restart_pulse(inoc_pkg::word_addr_t next_addr);
        fsm_restart <= 1'b1;
        @(negedge clk);
        check("restart_rd", 1, ibuffer_rd_start);
        check("restart_addr", next_addr, ibuffer_word_addr);
        @(posedge clk);
        fsm_restart <= 1'b0;
    endtask

    task automatic send_request(int n, inoc_pkg::flit_t rq);
        int cnt;
        bit taken;
        recv_flit[n]  <= rq;
        recv_valid[n] <= 1'b1;
        cnt = 0;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = recv_ready[n];
            cnt++;
            if (!taken && cnt > MAX_WAIT) abort_run("read request was never accepted");
        end
        recv_valid[n] <= 1'b0;
        recv_flit[n]  <= '0;
    endtask

    task automatic send_intr(int n, inoc_pkg::node_mask_t status, bit is_last);
        recv_flit[n]  <= {1'b1, 31'($urandom)};
        recv_valid[n] <= 1'b1;
        @(negedge clk);
        check("status_before_intr", status, nodes_status);
        check("intr_ready", 1, recv_ready[n]);
        check("loop_end_int", is_last, small_loop_end_int);
        @(posedge clk);
        recv_valid[n] <= 1'b0;
        recv_flit[n]  <= '0;
    endtask

    // config, one read request, a rejected repeat and all interrupts of a loop
    task automatic serve_loop(int first, int n, int next_first, int next_n);
        inoc_pkg::node_mask_t all, grp, dest;
        inoc_pkg::word_addr_t addr;
        inoc_pkg::flit_t      rq;
        int                   node, j, tmp;
        int                   order[$];
        bit                   is_async, is_long;
        all = '0;
        for (int r = first; r < first + n; r++) all |= rec_mask[r];
        wait_delivered("configuration flits");
        @(negedge clk);
        check("nodes_status", all, nodes_status);
        grp = rec_mask[first + $urandom % n];
        node = $urandom % inoc_pkg::NUM_NODES;
        while (!grp[node]) node = (node + 1) % inoc_pkg::NUM_NODES;
        is_async = $urandom;
        is_long = $urandom;
        addr = $urandom;
        dest = is_async ? inoc_pkg::node_mask_t'(1) << node : grp;
        queue_block(dest, is_long ? 32 : 16, addr);
        rq = {1'b0, 10'($urandom), is_async, is_long, addr, 2'($urandom)};
        @(posedge clk);
        send_request(node, rq);
        wait_delivered("data block");
        // delivered block clears the requester's entry
        recv_flit[node]  <= rq;
        recv_valid[node] <= 1'b1;
        repeat (6) begin
            @(negedge clk);
            check("request_rejected", 0, recv_ready[node]);
        end
        @(posedge clk);
        recv_valid[node] <= 1'b0;
        recv_flit[node]  <= '0;
        if (next_n > 0) queue_config(next_first, next_n);
        for (int i = 0; i < inoc_pkg::NUM_NODES; i++) begin
            if (all[i]) order.push_back(i);
        end
        for (int i = order.size() - 1; i > 0; i--) begin
            j = $urandom % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < order.size(); i++) begin
            send_intr(order[i], all, i == order.size() - 1);
            all[order[i]] = 1'b0;
        end
        @(negedge clk);
        check("status_cleared", 0, nodes_status);
        @(posedge clk);
    endtask

    // ================================================
    // instruction buffer and node models
    // ================================================
    initial begin : ibuffer_model
        inoc_pkg::word_addr_t a;
        int n, k, cnt;
        @(posedge clk);
        forever begin
            cnt = 0;
            while (ibuffer_rd_start !== 1'b1) begin
                cnt++;
                if (cnt > MAX_WAIT) abort_run("no buffer read request arrived");
                @(posedge clk);
            end
            a = ibuffer_word_addr;
            n = ibuffer_word_num;
            repeat ($urandom % 4) @(posedge clk);
            k = 0;
            while (k < n) begin
                if ($urandom % 4 == 0) begin
                    return_valid <= 1'b0;
                    @(posedge clk);
                end else begin
                    return_valid <= 1'b1;
                    return_data  <= mem[inoc_pkg::word_addr_t'(a + k)];
                    return_last  <= (k == n - 1);
                    cnt = 0;
                    @(posedge clk);
                    while (!return_ready) begin
                        cnt++;
                        if (cnt > MAX_WAIT) abort_run("buffer word was never taken");
                        @(posedge clk);
                    end
                    k++;
                end
            end
            return_valid <= 1'b0;
            return_last  <= 1'b0;
            return_done  <= 1'b1;
            @(posedge clk);
            return_done <= 1'b0;
        end
    end

    // a flit leaves once all its nodes are ready in the same cycle
    always @(posedge clk) begin
        if (finish_intr === 1'b1) begin
            // finish comes only after the loop end
            check("finish_after_loop_end", 0, nodes_status);
            fin_cnt++;
        end
        if (send_valid != '0 && (send_valid & ~send_ready) == '0) begin
            for (int i = 0; i < inoc_pkg::NUM_NODES; i++) begin
                if (send_valid[i]) begin
                    if (exp_q[i].size() == 0) begin
                        abort_run($sformatf("node %0d got unexpected flit %h", i, send_flit));
                    end else begin
                        check($sformatf("node%0d_flit", i), exp_q[i].pop_front(), send_flit);
                        pending--;
                    end
                end
            end
        end
        send_ready <= $urandom | $urandom;
    end

    // ================================================
    // test sequence
    // ================================================
    initial begin : main
        int nrec [4];
        int first [4];
        void'($urandom(32'h45a2));
        rst_n = 1'b0;
        fsm_start = 1'b0;
        fsm_base_addr = '0;
        fsm_auto_restart_en = 1'b0;
        fsm_restart = 1'b0;
        return_valid = 1'b0;
        return_data = '0;
        return_last = 1'b0;
        return_done = 1'b0;
        send_ready = '0;
        recv_valid = '0;
        recv_flit = '0;
        pending = 0;
        fin_cnt = 0;
        errors = 0;
        for (int a = 0; a < 2**17; a++) mem[a] = {a[14:0], a[16:0]};
        for (int l = 0; l < 4; l++) begin
            nrec[l] = 1 + $urandom % 6;
            first[l] = (l == 0) ? 0 : first[l - 1] + nrec[l - 1];
            build_loop(first[l], nrec[l], (l >= 2) ? inoc_pkg::op_finish : inoc_pkg::op_last);
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("reset_rd_start", 0, ibuffer_rd_start);
        check("reset_send_valid", 0, send_valid);
        check("reset_loop_end", 0, small_loop_end_int);
        check("reset_finish", 0, finish_intr);
        check("reset_status", 0, nodes_status);
        @(posedge clk);
        // loop 0 restarts into loop 1 on its own
        queue_config(first[0], nrec[0]);
        fsm_auto_restart_en <= 1'b1;
        start_unit(2 * first[0]);
        serve_loop(first[0], nrec[0], first[1], nrec[1]);
        fsm_auto_restart_en <= 1'b0;
        serve_loop(first[1], nrec[1], 0, 0);
        check("finish_count_l1", 0, fin_cnt);
        queue_config(first[2], nrec[2]);
        restart_pulse(2 * first[2]);
        serve_loop(first[2], nrec[2], 0, 0);
        wait_finish(1);
        // back in idle, a new start is taken
        queue_config(first[3], nrec[3]);
        start_unit(2 * first[3]);
        serve_loop(first[3], nrec[3], 0, 0);
        wait_finish(2);
        repeat (5) @(posedge clk);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== hw/inoc_ctrl_top.sv ====
// ================================================
// DMA control unit for a 12-node NoC, connects the
// sequencer, record FIFO, group table and arbiter
// ================================================
`timescale 1ns/100ps

module inoc_ctrl_top #(
    parameter int CFG_FIFO_DEPTH     = 16,
    parameter int INFO_BURST_RECORDS = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fsm_start,
    input  inoc_pkg::word_addr_t  fsm_base_addr,
    input  logic                  fsm_auto_restart_en,
    input  logic                  fsm_restart,
    output logic                  ibuffer_rd_start,
    output inoc_pkg::word_addr_t  ibuffer_word_addr,
    output inoc_pkg::word_num_t   ibuffer_word_num,
    input  logic                  return_valid,
    output logic                  return_ready,
    input  inoc_pkg::flit_t       return_data,
    input  logic                  return_last,
    input  logic                  return_done,
    output inoc_pkg::node_mask_t  send_valid,
    output inoc_pkg::flit_t       send_flit,
    input  inoc_pkg::node_mask_t  send_ready,
    input  inoc_pkg::node_mask_t  recv_valid,
    input  inoc_pkg::node_flits_t recv_flit,
    output inoc_pkg::node_mask_t  recv_ready,
    output inoc_pkg::node_mask_t  nodes_status,
    output logic                  small_loop_end_int,
    output logic                  finish_intr
);

    logic                 rec_push, rec_full, rec_valid, rec_pop;
    inoc_pkg::cfg_rec_t   rec_in, rec_out;
    logic                 group_wr;
    inoc_pkg::node_mask_t group_mask, gnt, gnt_group, recv_intr_valid;
    logic                 req_valid, req_release;
    inoc_pkg::noc_req_t   req;
    inoc_pkg::node_mask_t req_mask, done_mask;
    logic                 beat_valid, beat_ready, beat_done;
    inoc_pkg::send_beat_t beat;

    loop_sequencer #(.INFO_BURST_RECORDS(INFO_BURST_RECORDS)) u_seq (.*,
        .loop_end(small_loop_end_int));

    record_fifo #(.CFG_FIFO_DEPTH(CFG_FIFO_DEPTH)) u_rec_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(rec_push), .din(rec_in), .full(rec_full),
        .valid(rec_valid), .dout(rec_out), .pop(rec_pop)
    );

    group_table u_group_table (.*, .loop_end(small_loop_end_int));

    req_arbiter u_req_arb (.*);

    flit_broadcast u_bcast (.*);

endmodule

// ==== hw/loop_sequencer.sv ====
// ================================================
// main FSM: reads instruction records, broadcasts
// configuration, then serves node read requests
// ================================================
`timescale 1ns/100ps

module loop_sequencer #(
    parameter int INFO_BURST_RECORDS = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fsm_start,
    input  inoc_pkg::word_addr_t fsm_base_addr,
    input  logic                 fsm_auto_restart_en,
    input  logic                 fsm_restart,
    output logic                 ibuffer_rd_start,
    output inoc_pkg::word_addr_t ibuffer_word_addr,
    output inoc_pkg::word_num_t  ibuffer_word_num,
    input  logic                 return_valid,
    output logic                 return_ready,
    input  inoc_pkg::flit_t      return_data,
    input  logic                 return_last,
    input  logic                 return_done,
    output logic                 rec_push,
    output inoc_pkg::cfg_rec_t   rec_in,
    input  logic                 rec_full,
    input  logic                 rec_valid,
    input  inoc_pkg::cfg_rec_t   rec_out,
    output logic                 rec_pop,
    output logic                 group_wr,
    output inoc_pkg::node_mask_t group_mask,
    input  logic                 req_valid,
    input  inoc_pkg::noc_req_t   req,
    input  inoc_pkg::node_mask_t req_mask,
    output logic                 req_release,
    output logic                 beat_valid,
    output inoc_pkg::send_beat_t beat,
    input  logic                 beat_ready,
    input  logic                 beat_done,
    input  logic                 loop_end,
    output logic                 finish_intr
);

    localparam int CNT_W = $clog2(INFO_BURST_RECORDS + 1);

    inoc_pkg::seq_state_t state, state_nxt;
    inoc_pkg::word_addr_t info_addr;
    inoc_pkg::flit_t      cfg_flit_q;
    logic [CNT_W-1:0]     rec_cnt;
    logic ret_fire, grp_fire, loop_stop, is_finish;
    logic rec_half, burst_again, rd_busy, finish_q, loop_end_q;
    logic info_start, data_start;

    assign ret_fire   = return_valid && return_ready;
    // second word of a record is the group word
    assign grp_fire   = (state == inoc_pkg::rd_info) && ret_fire && rec_half;
    assign is_finish  = (return_data[6:0] == inoc_pkg::op_finish);
    assign loop_stop  = grp_fire && (is_finish || return_data[6:0] == inoc_pkg::op_last);
    assign group_mask = return_data[27:16];

    // ================================================
    // state machine
    // ================================================
    always_comb begin
        state_nxt = state;
        case (state)
            inoc_pkg::idle:      if (fsm_start) state_nxt = inoc_pkg::rd_info;
            inoc_pkg::rd_info:   if (loop_stop) state_nxt = inoc_pkg::send_cfg;
            inoc_pkg::send_cfg:  if (!rec_valid) state_nxt = inoc_pkg::recv_noc;
            inoc_pkg::recv_noc:  if (req_valid && !rd_busy) state_nxt = inoc_pkg::send_data;
            inoc_pkg::send_data: begin
                // a request captured after the release is the next one
                if (beat_done) begin
                    state_nxt = (req_valid && !req_release) ? inoc_pkg::recv_noc
                                                            : inoc_pkg::wait_intr;
                end
            end
            inoc_pkg::wait_intr: begin
                if (finish_q) begin
                    // finish interrupt follows the final loop end
                    if (loop_end_q) state_nxt = inoc_pkg::finish;
                end else if ((loop_end_q && fsm_auto_restart_en) || fsm_restart) begin
                    state_nxt = inoc_pkg::rd_info;
                end
            end
            default: state_nxt = inoc_pkg::idle;
        endcase
    end

    assign info_start = (state == inoc_pkg::idle && fsm_start) || burst_again ||
                        (state == inoc_pkg::wait_intr && state_nxt == inoc_pkg::rd_info);
    assign data_start = (state == inoc_pkg::recv_noc) && (state_nxt == inoc_pkg::send_data);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= inoc_pkg::idle;
            info_addr   <= '0;
            rec_half    <= 1'b0;
            rec_cnt     <= '0;
            burst_again <= 1'b0;
            rd_busy     <= 1'b0;
            finish_q    <= 1'b0;
            loop_end_q  <= 1'b0;
        end else begin
            state       <= state_nxt;
            burst_again <= grp_fire && !loop_stop &&
                           (rec_cnt == CNT_W'(INFO_BURST_RECORDS - 1));
            if (state == inoc_pkg::idle && fsm_start) begin
                info_addr <= fsm_base_addr;
            end else if (state == inoc_pkg::rd_info && ret_fire) begin
                info_addr <= info_addr + 1'b1;
            end
            if (info_start) begin
                rec_half <= 1'b0;
                rec_cnt  <= '0;
            end else if (state == inoc_pkg::rd_info && ret_fire) begin
                rec_half <= !rec_half;
                if (rec_half) rec_cnt <= rec_cnt + 1'b1;
            end
            // one read outstanding at a time
            if (ibuffer_rd_start) rd_busy <= 1'b1;
            else if (return_done) rd_busy <= 1'b0;
            if (state == inoc_pkg::finish) finish_q <= 1'b0;
            else if (loop_stop && is_finish) finish_q <= 1'b1;
            if (state == inoc_pkg::wait_intr && state_nxt != inoc_pkg::wait_intr) begin
                loop_end_q <= 1'b0;
            end else if (loop_end) begin
                loop_end_q <= 1'b1;
            end
        end
    end

    // configuration flit waits here for its group word
    always_ff @(posedge clk) begin
        if (state == inoc_pkg::rd_info && ret_fire && !rec_half) cfg_flit_q <= return_data;
    end

    // ================================================
    // buffer reads, record push and beat source
    // ================================================
    assign ibuffer_rd_start  = info_start || data_start;
    assign ibuffer_word_addr = data_start ? req.addr :
                               (state == inoc_pkg::idle) ? fsm_base_addr : info_addr;
    assign ibuffer_word_num  = !data_start ? inoc_pkg::word_num_t'(2 * INFO_BURST_RECORDS) :
                               req.is_long ? inoc_pkg::LONG_BLOCK_WORDS
                                           : inoc_pkg::SHORT_BLOCK_WORDS;

    always_comb begin
        case (state)
            inoc_pkg::rd_info:   return_ready = !rec_full;
            inoc_pkg::send_cfg:  return_ready = 1'b1;
            inoc_pkg::recv_noc:  return_ready = 1'b1;
            inoc_pkg::send_data: return_ready = beat_ready;
            default:             return_ready = 1'b0;
        endcase
    end

    assign rec_push    = grp_fire;
    assign group_wr    = grp_fire;
    assign rec_in      = '{mask: group_mask, flit: cfg_flit_q};
    assign rec_pop     = (state == inoc_pkg::send_cfg) && beat_ready;
    assign req_release = (state == inoc_pkg::send_data) && return_done;
    assign finish_intr = (state == inoc_pkg::finish);

    assign beat_valid = (state == inoc_pkg::send_cfg && rec_valid) ||
                        (state == inoc_pkg::send_data && return_valid);
    assign beat = (state == inoc_pkg::send_cfg) ?
                  inoc_pkg::send_beat_t'{dest: rec_out.mask, last: 1'b0, flit: rec_out.flit} :
                  inoc_pkg::send_beat_t'{dest: req_mask, last: return_last, flit: return_data};

endmodule

// ==== hw/flit_broadcast.sv ====
// ================================================
// register slice and fork of outgoing flits, a beat
// leaves once every masked node is ready
// ================================================
`timescale 1ns/100ps

module flit_broadcast (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 beat_valid,
    input  inoc_pkg::send_beat_t beat,
    output logic                 beat_ready,
    output inoc_pkg::node_mask_t send_valid,
    output inoc_pkg::flit_t      send_flit,
    input  inoc_pkg::node_mask_t send_ready,
    output logic                 beat_done,
    output inoc_pkg::node_mask_t done_mask
);

    inoc_pkg::send_beat_t slot;
    logic                 slot_valid;
    logic                 out_fire;

    // unmasked nodes do not hold the beat back
    assign out_fire   = slot_valid && (&(send_ready | ~slot.dest));
    assign beat_ready = !slot_valid || out_fire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
        end else if (beat_ready) begin
            slot_valid <= beat_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_ready && beat_valid) slot <= beat;
    end

    // ================================================
    // fork to the nodes
    // ================================================
    assign send_valid = slot.dest & {inoc_pkg::NUM_NODES{slot_valid}};
    assign send_flit  = slot.flit;
    assign beat_done  = out_fire && slot.last;
    assign done_mask  = slot.dest;

endmodule

// ==== hw/req_arbiter.sv ====
// ================================================
// round-robin arbiter for node read requests and
// the request hold register
// ================================================
`timescale 1ns/100ps

module req_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  inoc_pkg::node_mask_t  recv_valid,
    input  inoc_pkg::node_flits_t recv_flit,
    output inoc_pkg::node_mask_t  recv_ready,
    output inoc_pkg::node_mask_t  recv_intr_valid,
    output inoc_pkg::node_mask_t  gnt,
    input  inoc_pkg::node_mask_t  gnt_group,
    output logic                  req_valid,
    output inoc_pkg::noc_req_t    req,
    output inoc_pkg::node_mask_t  req_mask,
    input  logic                  req_release
);

    localparam int IW = $clog2(inoc_pkg::NUM_NODES);

    inoc_pkg::node_mask_t intr, req_vec, hold_gnt, hold_group;
    logic [IW-1:0]        last_gnt, gnt_idx;
    logic                 accept;

    always_comb begin
        for (int i = 0; i < inoc_pkg::NUM_NODES; i++) begin
            intr[i] = recv_flit[i][31];
        end
    end

    assign recv_intr_valid = recv_valid & intr;
    assign req_vec         = recv_valid & ~intr;

    // search starts after the last granted node
    always_comb begin
        int idx;
        gnt     = '0;
        gnt_idx = last_gnt;
        for (int k = inoc_pkg::NUM_NODES; k >= 1; k--) begin
            idx = (int'(last_gnt) + k) % inoc_pkg::NUM_NODES;
            if (req_vec[idx]) begin
                gnt     = inoc_pkg::node_mask_t'(1) << idx;
                gnt_idx = IW'(idx);
            end
        end
    end

    // requester must be in its own group
    assign accept     = !req_valid && ((gnt & gnt_group) != '0);
    assign recv_ready = (gnt & {inoc_pkg::NUM_NODES{accept}}) | intr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_gnt  <= IW'(inoc_pkg::NUM_NODES - 1);
            req_valid <= 1'b0;
        end else begin
            if (req_vec != '0) last_gnt <= gnt_idx;
            if (req_release) req_valid <= 1'b0;
            else if (accept) req_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req        <= inoc_pkg::noc_req_t'(recv_flit[gnt_idx][20:2]);
            hold_gnt   <= gnt;
            hold_group <= gnt_group;
        end
    end

    assign req_mask = req.is_async ? hold_gnt : hold_group;

endmodule

// ==== hw/group_table.sv ====
// ================================================
// per-node group lookup, busy-node status and the
// loop-end interrupt
// ================================================
`timescale 1ns/100ps

module group_table (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 group_wr,
    input  inoc_pkg::node_mask_t group_mask,
    input  inoc_pkg::node_mask_t gnt,
    output inoc_pkg::node_mask_t gnt_group,
    input  logic                 beat_done,
    input  inoc_pkg::node_mask_t done_mask,
    input  inoc_pkg::node_mask_t recv_intr_valid,
    output inoc_pkg::node_mask_t nodes_status,
    output logic                 loop_end
);

    inoc_pkg::node_mask_t lut [inoc_pkg::NUM_NODES];

    // each member node keeps the whole group mask
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < inoc_pkg::NUM_NODES; i++) begin
                lut[i] <= '0;
            end
        end else begin
            for (int i = 0; i < inoc_pkg::NUM_NODES; i++) begin
                if (group_wr && group_mask[i]) begin
                    lut[i] <= group_mask;
                end else if (beat_done && done_mask[i]) begin
                    // block delivered, node may not request again
                    lut[i] <= '0;
                end
            end
        end
    end

    // granted node selects its entry
    always_comb begin
        gnt_group = '0;
        for (int i = 0; i < inoc_pkg::NUM_NODES; i++) begin
            if (gnt[i]) gnt_group = gnt_group | lut[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nodes_status <= '0;
        end else begin
            nodes_status <= (nodes_status & ~recv_intr_valid) | (group_wr ? group_mask : '0);
        end
    end

    // last busy nodes interrupt in this cycle
    assign loop_end = (&(~nodes_status | recv_intr_valid)) && (nodes_status != '0);

endmodule

// ==== hw/record_fifo.sv ====
// ================================================
// circular FIFO of configuration records
// ================================================
`timescale 1ns/100ps

module record_fifo #(
    parameter int CFG_FIFO_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  inoc_pkg::cfg_rec_t din,
    output logic               full,
    output logic               valid,
    output inoc_pkg::cfg_rec_t dout,
    input  logic               pop
);

    localparam int AW = $clog2(CFG_FIFO_DEPTH);

    inoc_pkg::cfg_rec_t mem [CFG_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr, rd_ptr;
    logic [AW:0]   count;
    logic          wr_en, rd_en;

    assign full  = (count == (AW + 1)'(CFG_FIFO_DEPTH));
    assign valid = (count != '0);
    assign wr_en = push && !full;
    assign rd_en = pop && valid;
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at the depth, not only at a power of two
            if (wr_en) wr_ptr <= (wr_ptr == AW'(CFG_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= (rd_ptr == AW'(CFG_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + wr_en - rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= din;
    end

endmodule

// ==== hw/inoc_pkg.sv ====
// ================================================
// shared widths, opcodes, records and FSM states of
// the NoC DMA control unit, used by scoped names
// ================================================
package inoc_pkg;

    localparam int NUM_NODES = 12;
    // bit 31 of a flit marks an interrupt
    localparam int FLIT_W = 32;

    typedef logic [FLIT_W-1:0]    flit_t;
    typedef logic [NUM_NODES-1:0] node_mask_t;
    typedef flit_t [NUM_NODES-1:0] node_flits_t;
    typedef logic [16:0]          word_addr_t;
    typedef logic [12:0]          word_num_t;

    // group word opcode, bits 6:0
    typedef enum logic [6:0] {
        op_group  = 7'd1,
        op_last   = 7'd2,
        op_finish = 7'd3
    } opcode_t;

    localparam word_num_t SHORT_BLOCK_WORDS = 13'd16;
    localparam word_num_t LONG_BLOCK_WORDS  = 13'd32;

    // one configuration record, 44 bits
    typedef struct packed {
        node_mask_t mask;
        flit_t      flit;
    } cfg_rec_t;

    // one beat towards the nodes, 45 bits
    typedef struct packed {
        node_mask_t dest;
        logic       last;
        flit_t      flit;
    } send_beat_t;

    // read request, flit bits 20:2
    typedef struct packed {
        logic       is_async;
        logic       is_long;
        word_addr_t addr;
    } noc_req_t;

    typedef enum logic [2:0] {
        idle, rd_info, send_cfg, recv_noc, send_data, wait_intr, finish
    } seq_state_t;

endpackage
